// File: wavegen_top.f
+incdir+include
src/wavegen_cfg_pkg.sv
src/wavegen_stream_pkg.sv
src/param_bank.sv
src/trigger_timer.sv
src/triangle_core.sv
src/wavegen_top.sv
test/wavegen_tb.sv

// File: Makefile
# Verilator build and run for the triangle waveform generator

TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = wavegen_tb
FLIST = wavegen_top.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/wavegen_tests.txt
# Columns: W addr data | R addr expected | S data dest user | E (enable, wait for beats)
# All numbers are hex, addr is a register index from 0 to f
# Fill every register, CONTROL keeps bit 0 clear so the timer stays off
W 0 a5a50000
W 1 5a5a0001
W 2 28
W 3 14
W 4 8
W 5 2
W 6 d0000006
W 7 e0000007
W 8 8
W 9 fffffffe
W a 1010000a
W b 2020000b
W c 3030000c
W d 4040000d
W e 5050000e
W f 6060000f
R 0 a5a50000
R 1 5a5a0001
R 2 28
R 3 14
R 4 8
R 5 2
R 6 d0000006
R 7 e0000007
R 8 8
R 9 fffffffe
R a 1010000a
R b 2020000b
R c 3030000c
R d 4040000d
R e 5050000e
R f 6060000f
# Period 40, duty 8, step 2, phase 20: down to the duty point, then 6 and 8 in turn
S 14 d0000006 e0000007
S 12 d0000006 e0000007
S 10 d0000006 e0000007
S e d0000006 e0000007
S c d0000006 e0000007
S a d0000006 e0000007
S 8 d0000006 e0000007
S 6 d0000006 e0000007
S 8 d0000006 e0000007
S 6 d0000006 e0000007
E
W 9 0
# Count is 8 now, duty 40 and step 31 reach 39 and wrap to 0
W 4 28
W 5 1f
W 6 d1111116
W 7 e1111117
S 8 d1111116 e1111117
S 27 d1111116 e1111117
S 0 d1111116 e1111117
S 1f d1111116 e1111117
E
W 9 0
R 9 0
R 4 28

// File: test/wavegen_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the triangle waveform generator
// Replays the command file from test/ on the host bus
// and checks register readback and every output beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module wavegen_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                          clock;
    logic                          rst_n;
    wavegen_cfg_pkg::host_op_e     op;
    logic [3:0]                    addr;
    logic [31:0]                   wdata;
    logic [31:0]                   rdata;
    logic                          rvalid;
    logic                          valid;
    logic                          tlast;
    wavegen_stream_pkg::sample_t   data;
    wavegen_stream_pkg::dest_t     dest;
    wavegen_stream_pkg::user_t     user;

    // The three expected-beat queues always move together
    wavegen_stream_pkg::sample_t exp_data_q[$];
    wavegen_stream_pkg::dest_t   exp_dest_q[$];
    wavegen_stream_pkg::user_t   exp_user_q[$];

    int   value_errors = 0;
    int   other_errors = 0;
    int   cycles = 0;
    int   cycle_limit = 0;
    logic valid_prev = 1'b0;

    wavegen_top i_wavegen_top (
        .clock  (clock),
        .rst_n  (rst_n),
        .op     (op),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rvalid),
        .valid  (valid),
        .tlast  (tlast),
        .data   (data),
        .dest   (dest),
        .user   (user)
    );

    // 4 ns clock period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Hard stop once the run takes longer than the command file allows
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the expected beats never all arrived", cycles);
            other_errors++;
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_sample(input wavegen_stream_pkg::sample_t exp,
                                input wavegen_stream_pkg::sample_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t data expected 0x%08h actual 0x%08h", $time, exp, act);
            value_errors++;
        end
    endtask

    // Used for both dest and user with the signal name in the error line
    task automatic check_word(input string name, input wavegen_stream_pkg::dest_t exp,
                              input wavegen_stream_pkg::dest_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_read(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t rdata expected 0x%08h actual 0x%08h", $time, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // Outputs are looked at on the falling edge well away from any update
    always @(negedge clock) begin : beat_monitor
        wavegen_stream_pkg::sample_t want_data;
        wavegen_stream_pkg::dest_t   want_dest;
        wavegen_stream_pkg::user_t   want_user;
        if (rst_n && valid) begin
            if (valid_prev) begin
                $display("At %0t valid stayed high for more than one cycle", $time);
                other_errors++;
            end
            check_flag("tlast", 1'b1, tlast);
            if (exp_data_q.size() == 0) begin
                $display("At %0t a beat with data 0x%08h arrived while none was expected",
                         $time, data);
                other_errors++;
            end else begin
                want_data = exp_data_q.pop_front();
                want_dest = exp_dest_q.pop_front();
                want_user = exp_user_q.pop_front();
                check_sample(want_data, data);
                check_word("dest", want_dest, dest);
                check_word("user", want_user, user);
            end
        end
        valid_prev = valid;
    end

    // Every host task starts and ends 1 ns after a rising edge
    task automatic host_write(input logic [3:0] a, input logic [31:0] d);
        op    = wavegen_cfg_pkg::OP_WRITE;
        addr  = a;
        wdata = d;
        @(posedge clock);
        #1;
        op = wavegen_cfg_pkg::OP_IDLE;
    endtask

    // The response must appear in the cycle after the strobe and only then
    task automatic host_read(input logic [3:0] a, input logic [31:0] expected);
        op   = wavegen_cfg_pkg::OP_READ;
        addr = a;
        @(posedge clock);
        #1;
        op = wavegen_cfg_pkg::OP_IDLE;
        @(negedge clock);
        if (!rvalid) begin
            $display("At %0t rvalid was missing in the cycle after the read of register %0d",
                     $time, a);
            other_errors++;
        end else begin
            check_read(expected, rdata);
        end
        @(negedge clock);
        if (rvalid) begin
            $display("At %0t rvalid stayed high a second cycle after one read", $time);
            other_errors++;
        end
        @(posedge clock);
        #1;
    endtask

    // Turn the timer on and wait for the monitor to empty the queue
    task automatic run_until_drained();
        host_write(4'd9, 32'd1);
        while (exp_data_q.size() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          n_lines;
        string       line;
        string       lines_q[$];
        byte         cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;

        op      = wavegen_cfg_pkg::OP_IDLE;
        addr    = '0;
        wdata   = '0;
        rst_n   = 1'b0;
        n_lines = 0;

        fd = $fopen("test/wavegen_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file test/wavegen_tests.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    n_lines++;
                    lines_q.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_lines * 64 + 200;

        // Two cycles of reset released just after an edge
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        foreach (lines_q[i]) begin
            line = lines_q[i];
            cmd  = line.getc(0);
            case (cmd)
                "W": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
                    if (n == 2) begin
                        host_write(f1[3:0], f2);
                    end else begin
                        $display("Line %0d of the command file is malformed", i + 1);
                        other_errors++;
                    end
                end
                "R": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
                    if (n == 2) begin
                        host_read(f1[3:0], f2);
                    end else begin
                        $display("Line %0d of the command file is malformed", i + 1);
                        other_errors++;
                    end
                end
                "S": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f1, f2, f3);
                    if (n == 3) begin
                        exp_data_q.push_back(f1);
                        exp_dest_q.push_back(f2);
                        exp_user_q.push_back(f3);
                    end else begin
                        $display("Line %0d of the command file is malformed", i + 1);
                        other_errors++;
                    end
                end
                "E": run_until_drained();
                default: begin
                    // Comments and blank lines carry no command
                    if (cmd != "#" && cmd != "\n" && cmd != 8'h0d && cmd != " ") begin
                        $display("Line %0d of the command file has an unknown command", i + 1);
                        other_errors++;
                    end
                end
            endcase
        end

        // Quiet tail so that a stray beat after the last disable is still seen
        repeat (40) @(posedge clock);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/wavegen_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Triangle waveform generator top level
// Host bus in, one beat per sample tick out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module wavegen_top (
    input  logic                          clock,
    input  logic                          rst_n,
    input  wavegen_cfg_pkg::host_op_e     op,
    input  logic [3:0]                    addr,
    input  logic [31:0]                   wdata,
    output logic [31:0]                   rdata,
    output logic                          rvalid,
    output logic                          valid,
    output logic                          tlast,
    output wavegen_stream_pkg::sample_t   data,
    output wavegen_stream_pkg::dest_t     dest,
    output wavegen_stream_pkg::user_t     user
);

    // Parameter words from the bank
    logic [31:0] period;
    logic [31:0] phase;
    logic [31:0] duty;
    logic [31:0] ramp_inc;
    logic [31:0] dest_word;
    logic [31:0] user_word;
    logic [31:0] divider;
    logic        enable;

    // Sample strobe from the timer into the core
    logic        tick;

    param_bank i_param_bank (
        .clock    (clock),
        .rst_n    (rst_n),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .period   (period),
        .phase    (phase),
        .duty     (duty),
        .ramp_inc (ramp_inc),
        .dest     (dest_word),
        .user     (user_word),
        .divider  (divider),
        .enable   (enable)
    );

    trigger_timer i_trigger_timer (
        .clock   (clock),
        .rst_n   (rst_n),
        .enable  (enable),
        .divider (divider),
        .tick    (tick)
    );

    // Tick to beat latency is one cycle through this register stage
    triangle_core i_triangle_core (
        .clock     (clock),
        .rst_n     (rst_n),
        .tick      (tick),
        .period    (period),
        .phase     (phase),
        .duty      (duty),
        .ramp_inc  (ramp_inc),
        .dest_word (dest_word),
        .user_word (user_word),
        .valid     (valid),
        .tlast     (tlast),
        .data      (data),
        .dest      (dest),
        .user      (user)
    );

endmodule

`default_nettype wire

// File: src/triangle_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Triangle ramp counter and output beat generator
// First tick arms the core, each later tick emits one beat
// No back-pressure, a missed beat is simply gone
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "wavegen_consts.svh"

module triangle_core (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          tick,
    input  logic [31:0]                   period,
    input  logic [31:0]                   phase,
    input  logic [31:0]                   duty,
    input  logic [31:0]                   ramp_inc,
    input  wavegen_stream_pkg::dest_t     dest_word,
    input  wavegen_stream_pkg::user_t     user_word,
    output logic                          valid,
    output logic                          tlast,
    output wavegen_stream_pkg::sample_t   data,
    output wavegen_stream_pkg::dest_t     dest,
    output wavegen_stream_pkg::user_t     user
);

    wavegen_stream_pkg::core_state_e state;
    logic [`WG_CNT_W-1:0]            cnt;

    // Parameter words cut to the counter width
    logic [`WG_CNT_W-1:0] period_c;
    logic [`WG_CNT_W-1:0] phase_c;
    logic [`WG_CNT_W-1:0] duty_c;
    logic [`WG_CNT_W-1:0] inc_c;

    assign period_c = period[`WG_CNT_W-1:0];
    assign phase_c  = phase[`WG_CNT_W-1:0];
    assign duty_c   = duty[`WG_CNT_W-1:0];
    assign inc_c    = ramp_inc[`WG_CNT_W-1:0];

    // Above the duty point the ramp runs down, at or below it runs up
    // A duty of zero wraps duty-1 to all ones so the ramp only rises
    logic down_ramp;
    logic at_wrap;
    assign down_ramp = (cnt > duty_c - `WG_CNT_W'(1));
    assign at_wrap   = (cnt == period_c - `WG_CNT_W'(1));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= wavegen_stream_pkg::CORE_IDLE;
            cnt   <= '0;
            valid <= 1'b0;
            tlast <= 1'b0;
            data  <= '0;
            dest  <= '0;
            user  <= '0;
        end else begin
            // Beat strobes default low so each beat is a single cycle
            valid <= 1'b0;
            tlast <= 1'b0;
            if (state == wavegen_stream_pkg::CORE_IDLE) begin
                // Phase keeps tracking the register until the core arms
                cnt <= phase_c;
                if (tick) begin
                    state <= wavegen_stream_pkg::CORE_RUN;
                end
            end else if (tick) begin
                if (at_wrap) begin
                    cnt <= '0;
                end else if (down_ramp) begin
                    cnt <= cnt - inc_c;
                end else begin
                    cnt <= cnt + inc_c;
                end
                // The beat carries the count from before this update
                data  <= {{(`WG_WORD_W - `WG_CNT_W){1'b0}}, cnt};
                dest  <= dest_word;
                user  <= user_word;
                valid <= 1'b1;
                tlast <= 1'b1;
            end
        end
    end

    // Each beat is a complete packet of one word
    a_valid_tlast: assert property (
        @(posedge clock) disable iff (!rst_n)
        valid |-> tlast
    );

    // The arming tick must never produce a beat
    a_valid_after_run: assert property (
        @(posedge clock) disable iff (!rst_n)
        valid |-> $past(state) == wavegen_stream_pkg::CORE_RUN
    );

endmodule

`default_nettype wire

// File: src/trigger_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample tick divider for the triangle core
// Emits a one-cycle tick every divider cycles while enabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trigger_timer (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [31:0] divider,
    output logic        tick
);

    // Cycles left until the next tick, zero means freshly enabled
    logic [31:0] count;

    // Divider values 0 and 1 both mean a tick on every cycle
    logic every_cycle;
    assign every_cycle = (divider < 32'd2);

    always_ff @(posedge clock) begin
        if (!rst_n || !enable) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (every_cycle) begin
            count <= '0;
            tick  <= 1'b1;
        end else if (count == 32'd1) begin
            // Tick now and reload for a full period
            count <= divider;
            tick  <= 1'b1;
        end else if (count == '0) begin
            // First enabled edge, already one cycle into the period
            count <= divider - 32'd1;
            tick  <= 1'b0;
        end else begin
            count <= count - 32'd1;
            tick  <= 1'b0;
        end
    end

    // With a real division the pulse must drop after one cycle
    a_tick_single: assert property (
        @(posedge clock) disable iff (!rst_n)
        (tick && divider >= 32'd2) |=> !tick
    );

endmodule

`default_nettype wire

// File: src/param_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parameter register file on the host strobe bus
// Writes land on the op edge, reads return one cycle later
// Named words are broken out for the timer and the core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "wavegen_consts.svh"

module param_bank (
    input  logic                       clock,
    input  logic                       rst_n,
    input  wavegen_cfg_pkg::host_op_e  op,
    input  logic [3:0]                 addr,
    input  logic [`WG_WORD_W-1:0]      wdata,
    output logic [`WG_WORD_W-1:0]      rdata,
    output logic                       rvalid,
    output logic [`WG_WORD_W-1:0]      period,
    output logic [`WG_WORD_W-1:0]      phase,
    output logic [`WG_WORD_W-1:0]      duty,
    output logic [`WG_WORD_W-1:0]      ramp_inc,
    output logic [`WG_WORD_W-1:0]      dest,
    output logic [`WG_WORD_W-1:0]      user,
    output logic [`WG_WORD_W-1:0]      divider,
    output logic                       enable
);

    // Full bank of words, every index is writable and readable
    logic [`WG_WORD_W-1:0] regs [`WG_N_PARAMS];

    // Storage and readback share one clocked block
    // A read in the same cycle as a write to that index sees the old word
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `WG_N_PARAMS; i++) begin
                regs[i] <= '0;
            end
            rdata  <= '0;
            rvalid <= 1'b0;
        end else begin
            if (op == wavegen_cfg_pkg::OP_WRITE) begin
                regs[addr] <= wdata;
            end
            // rvalid is a one-cycle echo of the read strobe
            rvalid <= (op == wavegen_cfg_pkg::OP_READ);
            if (op == wavegen_cfg_pkg::OP_READ) begin
                rdata <= regs[addr];
            end
        end
    end

    // Field breakout by register map position
    // DC offset and amplitude are only reachable through readback
    assign period   = regs[wavegen_cfg_pkg::PERIOD];
    assign phase    = regs[wavegen_cfg_pkg::PHASE];
    assign duty     = regs[wavegen_cfg_pkg::DUTY];
    assign ramp_inc = regs[wavegen_cfg_pkg::RAMP_INC];
    assign dest     = regs[wavegen_cfg_pkg::DEST];
    assign user     = regs[wavegen_cfg_pkg::USER];
    assign divider  = regs[wavegen_cfg_pkg::DIVIDER];
    // Only bit 0 of the control word has a meaning today
    assign enable   = regs[wavegen_cfg_pkg::CONTROL][0];

    // A response never shows up without a read strobe one cycle before
    a_rvalid_follows_read: assert property (
        @(posedge clock) disable iff (!rst_n)
        rvalid |-> $past(op) == wavegen_cfg_pkg::OP_READ
    );

endmodule

`default_nettype wire

// File: src/wavegen_stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output side types: core state and beat fields
// Used by the triangle core and the top level ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "wavegen_consts.svh"

package wavegen_stream_pkg;

    // The core sits in CORE_IDLE until the first tick arms it
    typedef enum logic {
        CORE_IDLE = 1'b0,
        CORE_RUN  = 1'b1
    } core_state_e;

    // Fields carried by every output beat
    typedef logic [`WG_WORD_W-1:0] sample_t;
    typedef logic [`WG_WORD_W-1:0] dest_t;
    typedef logic [`WG_WORD_W-1:0] user_t;

endpackage

`default_nettype wire

// File: src/wavegen_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host side types: register map and bus opcodes
// Referenced by scoped name from the bank and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package wavegen_cfg_pkg;

    // Position of each named parameter word in the bank
    // Indices 10 to 15 are plain storage with no function
    typedef enum logic [3:0] {
        DC_OFFSET = 4'd0,
        AMPLITUDE = 4'd1,
        PERIOD    = 4'd2,
        PHASE     = 4'd3,
        DUTY      = 4'd4,
        RAMP_INC  = 4'd5,
        DEST      = 4'd6,
        USER      = 4'd7,
        DIVIDER   = 4'd8,
        CONTROL   = 4'd9
    } param_index_e;

    // Host bus command, held for a single cycle by the host
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } host_op_e;

endpackage

`default_nettype wire

// File: include/wavegen_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing constants for the triangle waveform generator
// Include this wherever the bank depth or data widths are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef WAVEGEN_CONSTS_SVH
`define WAVEGEN_CONSTS_SVH

// Number of host-visible parameter words, addressed by a 4 bit index
`define WG_N_PARAMS 16

// Width of a parameter word and of an output sample
`define WG_WORD_W 32

// Width of the ramp counter inside the core
// Period, phase, duty and increment words are cut down to this width
`define WG_CNT_W 24

`endif
